//--- riscv_csr_macros.svh
`ifndef RISCV_CSR_MACROS_SVH
`define RISCV_CSR_MACROS_SVH

`define RISCV_CSR_XLEN            64

`define RISCV_CSR_MTVEC_RST       64'h0000_0000_0000_0048  // Base 0x48, direct mode
`define RISCV_CSR_MISA_VAL        64'h8000_0000_0010_0100  // MXL=2, U and I extensions
`define RISCV_CSR_MIE_MASK        64'h0000_0000_0000_0880  // MEIE and MTIE only

`define RISCV_CSR_MSTATUS_MIE     3
`define RISCV_CSR_MSTATUS_MPIE    7
`define RISCV_CSR_MSTATUS_MPP_LO  11                       // MPP occupies bits 12:11

`define RISCV_CSR_MTI_BIT         7
`define RISCV_CSR_MEI_BIT         11

`endif

//--- riscv_csr_pkg.sv
package riscv_csr_pkg;

  typedef enum logic [11:0] {
    MSTATUS  = 12'h300,
    MISA     = 12'h301,
    MIE      = 12'h304,
    MTVEC    = 12'h305,
    MSCRATCH = 12'h340,
    MEPC     = 12'h341,
    MCAUSE   = 12'h342,
    MTVAL    = 12'h343,
    MIP      = 12'h344,
    MHARTID  = 12'hF14
  } csr_addr_e;

  typedef enum logic [2:0] {
    CSR_NONE  = 3'd0,
    CSR_WRITE = 3'd1,
    CSR_SET   = 3'd2,
    CSR_CLEAR = 3'd3,
    CSR_READ  = 3'd4,
    CSR_MRET  = 3'd5
  } csr_op_e;

  typedef enum logic [1:0] {
    PRIV_U = 2'b00,
    PRIV_M = 2'b11
  } priv_lvl_e;

  typedef enum logic [3:0] {
    CAUSE_INST_MISALIGNED  = 4'd0,
    CAUSE_ILLEGAL          = 4'd2,
    CAUSE_LOAD_MISALIGNED  = 4'd4,
    CAUSE_STORE_MISALIGNED = 4'd6,
    CAUSE_MTI              = 4'd7,
    CAUSE_ECALL_U          = 4'd8,
    CAUSE_ECALL_M          = 4'd11
  } trap_cause_e;

  // Same code as ECALL_M, the interrupt flag tells them apart
  localparam trap_cause_e CAUSE_MEI = CAUSE_ECALL_M;

endpackage

//--- riscv_csr_access.sv
`include "riscv_csr_macros.svh"

module riscv_csr_access
  import riscv_csr_pkg::*;
(
  input  csr_op_e                    i_riscv_csr_op,
  input  logic [11:0]                i_riscv_csr_address,
  input  logic [`RISCV_CSR_XLEN-1:0] i_riscv_csr_wdata,
  input  logic [`RISCV_CSR_XLEN-1:0] i_riscv_csr_rdata,
  input  logic                       i_riscv_csr_read_unknown,
  input  priv_lvl_e                  i_riscv_csr_priv,
  input  logic                       i_riscv_csr_stall,
  output logic                       o_riscv_csr_wr_en,
  output logic [`RISCV_CSR_XLEN-1:0] o_riscv_csr_wr_data,
  output logic                       o_riscv_csr_mret,
  output logic                       o_riscv_csr_illegal
);

  logic is_access;     // Any CSR read or write
  logic is_write;      // Write, set or clear
  logic is_mret;
  logic illegal_ro;    // Write to read-only space
  logic illegal_priv;  // CSR above current level

  always_comb
  begin
    is_access           = 1'b1;
    is_write            = 1'b0;
    is_mret             = 1'b0;
    o_riscv_csr_wr_data = i_riscv_csr_wdata;
    case (i_riscv_csr_op)
      CSR_WRITE : is_write = 1'b1;
      CSR_SET   :
      begin
        is_write            = 1'b1;
        o_riscv_csr_wr_data = i_riscv_csr_rdata | i_riscv_csr_wdata;
      end
      CSR_CLEAR :
      begin
        is_write            = 1'b1;
        o_riscv_csr_wr_data = i_riscv_csr_rdata & ~i_riscv_csr_wdata;
      end
      CSR_READ  : is_write = 1'b0;
      CSR_MRET  :
      begin
        is_access = 1'b0;
        is_mret   = 1'b1;
      end
      default   : is_access = 1'b0;  // NONE and the two spare codes
    endcase
  end

  assign illegal_ro   = is_write && (i_riscv_csr_address[11:10] == 2'b11);
  assign illegal_priv = i_riscv_csr_address[9:8] > i_riscv_csr_priv;

  assign o_riscv_csr_illegal = is_access &&
                               (i_riscv_csr_read_unknown || illegal_ro || illegal_priv);

  assign o_riscv_csr_wr_en = is_write && !o_riscv_csr_illegal && !i_riscv_csr_stall;
  assign o_riscv_csr_mret  = is_mret && !i_riscv_csr_stall;

endmodule

//--- riscv_csr_regs.sv
`include "riscv_csr_macros.svh"

module riscv_csr_regs
  import riscv_csr_pkg::*;
(
  input  logic                       i_riscv_csr_clk,
  input  logic                       i_riscv_csr_rst,
  input  logic [11:0]                i_riscv_csr_address,
  input  logic                       i_riscv_csr_wr_en,
  input  logic [`RISCV_CSR_XLEN-1:0] i_riscv_csr_wr_data,
  input  logic                       i_riscv_csr_mret,
  input  logic                       i_riscv_csr_trap_taken,
  input  trap_cause_e                i_riscv_csr_trap_cause,
  input  logic                       i_riscv_csr_trap_is_int,
  input  logic                       i_riscv_csr_tval_wr,
  input  logic [`RISCV_CSR_XLEN-1:0] i_riscv_csr_tval,
  input  logic [`RISCV_CSR_XLEN-1:0] i_riscv_csr_pc,
  input  logic                       i_riscv_csr_timer_int,
  input  logic                       i_riscv_csr_external_int,
  output logic [`RISCV_CSR_XLEN-1:0] o_riscv_csr_rdata,
  output logic                       o_riscv_csr_read_unknown,
  output priv_lvl_e                  o_riscv_csr_priv,
  output logic                       o_riscv_csr_mstatus_mie,
  output logic [`RISCV_CSR_XLEN-1:0] o_riscv_csr_mie,
  output logic [`RISCV_CSR_XLEN-1:0] o_riscv_csr_mip,
  output logic [`RISCV_CSR_XLEN-1:0] o_riscv_csr_mtvec,
  output logic [`RISCV_CSR_XLEN-1:0] o_riscv_csr_mepc
);

  logic                       mstatus_mie;
  logic                       mstatus_mpie;
  priv_lvl_e                  mstatus_mpp;
  priv_lvl_e                  priv_q;
  logic [`RISCV_CSR_XLEN-1:0] mie_q;
  logic [`RISCV_CSR_XLEN-1:0] mip_q;
  logic [`RISCV_CSR_XLEN-1:0] mtvec_q;
  logic [`RISCV_CSR_XLEN-1:0] mscratch_q;
  logic [`RISCV_CSR_XLEN-1:0] mepc_q;
  logic [`RISCV_CSR_XLEN-1:0] mtval_q;
  logic                       mcause_int;
  logic [3:0]                 mcause_code;
  logic                       csr_wr;  // Write survives trap and MRET

  assign csr_wr = i_riscv_csr_wr_en && !i_riscv_csr_trap_taken && !i_riscv_csr_mret;

  always_comb
  begin
    o_riscv_csr_rdata        = '0;
    o_riscv_csr_read_unknown = 1'b0;
    case (i_riscv_csr_address)
      MSTATUS  :
      begin
        o_riscv_csr_rdata[`RISCV_CSR_MSTATUS_MIE]  = mstatus_mie;
        o_riscv_csr_rdata[`RISCV_CSR_MSTATUS_MPIE] = mstatus_mpie;
        o_riscv_csr_rdata[`RISCV_CSR_MSTATUS_MPP_LO+1:`RISCV_CSR_MSTATUS_MPP_LO] = mstatus_mpp;
      end
      MISA     : o_riscv_csr_rdata = `RISCV_CSR_MISA_VAL;
      MIE      : o_riscv_csr_rdata = mie_q;
      MTVEC    : o_riscv_csr_rdata = mtvec_q;
      MSCRATCH : o_riscv_csr_rdata = mscratch_q;
      MEPC     : o_riscv_csr_rdata = mepc_q;
      MCAUSE   : o_riscv_csr_rdata = {mcause_int, {(`RISCV_CSR_XLEN-5){1'b0}}, mcause_code};
      MTVAL    : o_riscv_csr_rdata = mtval_q;
      MIP      : o_riscv_csr_rdata = mip_q;
      MHARTID  : o_riscv_csr_rdata = '0;  // Single hart
      default  : o_riscv_csr_read_unknown = 1'b1;
    endcase
  end

  // MSTATUS and privilege
  always_ff @(posedge i_riscv_csr_clk or posedge i_riscv_csr_rst)
  begin
    if (i_riscv_csr_rst)
    begin
      mstatus_mie  <= 1'b0;
      mstatus_mpie <= 1'b0;
      mstatus_mpp  <= PRIV_U;
      priv_q       <= PRIV_M;
    end
    else if (i_riscv_csr_trap_taken)
    begin
      mstatus_mpie <= mstatus_mie;
      mstatus_mie  <= 1'b0;
      mstatus_mpp  <= priv_q;
      priv_q       <= PRIV_M;
    end
    else if (i_riscv_csr_mret)
    begin
      mstatus_mie  <= mstatus_mpie;
      mstatus_mpie <= 1'b1;
      mstatus_mpp  <= PRIV_U;
      priv_q       <= mstatus_mpp;
    end
    else if (csr_wr && (i_riscv_csr_address == MSTATUS))
    begin
      mstatus_mie  <= i_riscv_csr_wr_data[`RISCV_CSR_MSTATUS_MIE];
      mstatus_mpie <= i_riscv_csr_wr_data[`RISCV_CSR_MSTATUS_MPIE];
      // Only U and M exist, any other MPP encoding lands on U
      mstatus_mpp  <= (i_riscv_csr_wr_data[`RISCV_CSR_MSTATUS_MPP_LO+1:
                                           `RISCV_CSR_MSTATUS_MPP_LO] == 2'b11) ? PRIV_M : PRIV_U;
    end
  end

  // Plain software registers
  always_ff @(posedge i_riscv_csr_clk or posedge i_riscv_csr_rst)
  begin
    if (i_riscv_csr_rst)
    begin
      mie_q      <= '0;
      mtvec_q    <= `RISCV_CSR_MTVEC_RST;
      mscratch_q <= '0;
    end
    else if (csr_wr)
    begin
      case (i_riscv_csr_address)
        MIE      : mie_q      <= i_riscv_csr_wr_data & `RISCV_CSR_MIE_MASK;
        MTVEC    : mtvec_q    <= {i_riscv_csr_wr_data[`RISCV_CSR_XLEN-1:2], 1'b0,
                                  i_riscv_csr_wr_data[0]};
        MSCRATCH : mscratch_q <= i_riscv_csr_wr_data;
        default  : mscratch_q <= mscratch_q;
      endcase
    end
  end

  // Pending bits track the lines, one cycle late
  always_ff @(posedge i_riscv_csr_clk or posedge i_riscv_csr_rst)
  begin
    if (i_riscv_csr_rst)
      mip_q <= '0;
    else
    begin
      mip_q                     <= '0;
      mip_q[`RISCV_CSR_MTI_BIT] <= i_riscv_csr_timer_int;
      mip_q[`RISCV_CSR_MEI_BIT] <= i_riscv_csr_external_int;
    end
  end

  // Trap state
  always_ff @(posedge i_riscv_csr_clk or posedge i_riscv_csr_rst)
  begin
    if (i_riscv_csr_rst)
    begin
      mepc_q      <= '0;
      mcause_int  <= 1'b0;
      mcause_code <= '0;
      mtval_q     <= '0;
    end
    else if (i_riscv_csr_trap_taken)
    begin
      mepc_q      <= i_riscv_csr_pc;
      mcause_int  <= i_riscv_csr_trap_is_int;
      mcause_code <= i_riscv_csr_trap_cause;
      if (i_riscv_csr_tval_wr)
        mtval_q <= i_riscv_csr_tval;
    end
    else if (csr_wr)
    begin
      case (i_riscv_csr_address)
        MEPC    : mepc_q <= {i_riscv_csr_wr_data[`RISCV_CSR_XLEN-1:1], 1'b0};
        MCAUSE  :
        begin
          mcause_int  <= i_riscv_csr_wr_data[`RISCV_CSR_XLEN-1];
          mcause_code <= i_riscv_csr_wr_data[3:0];
        end
        MTVAL   : mtval_q <= i_riscv_csr_wr_data;
        default : mtval_q <= mtval_q;
      endcase
    end
  end

  assign o_riscv_csr_priv        = priv_q;
  assign o_riscv_csr_mstatus_mie = mstatus_mie;
  assign o_riscv_csr_mie         = mie_q;
  assign o_riscv_csr_mip         = mip_q;
  assign o_riscv_csr_mtvec       = mtvec_q;
  assign o_riscv_csr_mepc        = mepc_q;

endmodule

//--- riscv_csr_trap_ctrl.sv
`include "riscv_csr_macros.svh"

module riscv_csr_trap_ctrl
  import riscv_csr_pkg::*;
(
  input  priv_lvl_e                  i_riscv_csr_priv,
  input  logic                       i_riscv_csr_mstatus_mie,
  input  logic [`RISCV_CSR_XLEN-1:0] i_riscv_csr_mie,
  input  logic [`RISCV_CSR_XLEN-1:0] i_riscv_csr_mip,
  input  logic [`RISCV_CSR_XLEN-1:0] i_riscv_csr_mtvec,
  input  logic                       i_riscv_csr_illegal_csr,
  input  logic                       i_riscv_csr_illegal_inst,
  input  logic                       i_riscv_csr_ecall,
  input  logic                       i_riscv_csr_inst_addr_misaligned,
  input  logic                       i_riscv_csr_load_addr_misaligned,
  input  logic                       i_riscv_csr_store_addr_misaligned,
  input  logic [`RISCV_CSR_XLEN-1:0] i_riscv_csr_fault_addr,
  input  logic [31:0]                i_riscv_csr_inst,
  input  logic                       i_riscv_csr_flush,
  input  logic                       i_riscv_csr_stall,
  output logic                       o_riscv_csr_trap_taken,
  output trap_cause_e                o_riscv_csr_trap_cause,
  output logic                       o_riscv_csr_trap_is_int,
  output logic                       o_riscv_csr_tval_wr,
  output logic [`RISCV_CSR_XLEN-1:0] o_riscv_csr_tval,
  output logic [`RISCV_CSR_XLEN-1:0] o_riscv_csr_trap_address
);

  logic                       int_enable;  // Always on below M
  logic                       mei_go;
  logic                       mti_go;
  logic                       illegal;
  logic                       exc_go;
  logic [`RISCV_CSR_XLEN-1:0] trap_base;

  assign int_enable = (i_riscv_csr_priv == PRIV_U) || i_riscv_csr_mstatus_mie;
  assign mei_go     = i_riscv_csr_mie[`RISCV_CSR_MEI_BIT] && i_riscv_csr_mip[`RISCV_CSR_MEI_BIT] &&
                      int_enable;
  assign mti_go     = i_riscv_csr_mie[`RISCV_CSR_MTI_BIT] && i_riscv_csr_mip[`RISCV_CSR_MTI_BIT] &&
                      int_enable;

  assign illegal = i_riscv_csr_illegal_csr || i_riscv_csr_illegal_inst;
  assign exc_go  = illegal || i_riscv_csr_inst_addr_misaligned || i_riscv_csr_ecall ||
                   i_riscv_csr_load_addr_misaligned || i_riscv_csr_store_addr_misaligned;

  assign o_riscv_csr_trap_is_int = mei_go || mti_go;
  assign o_riscv_csr_trap_taken  = (o_riscv_csr_trap_is_int || exc_go) &&
                                   !i_riscv_csr_flush && !i_riscv_csr_stall;

  // Interrupts first, then exceptions in fixed order
  always_comb
  begin
    o_riscv_csr_trap_cause = CAUSE_INST_MISALIGNED;
    o_riscv_csr_tval_wr    = 1'b0;
    o_riscv_csr_tval       = i_riscv_csr_fault_addr;
    if (mei_go)
      o_riscv_csr_trap_cause = CAUSE_MEI;
    else if (mti_go)
      o_riscv_csr_trap_cause = CAUSE_MTI;
    else if (illegal)
    begin
      o_riscv_csr_trap_cause = CAUSE_ILLEGAL;
      o_riscv_csr_tval_wr    = 1'b1;
      o_riscv_csr_tval       = {{(`RISCV_CSR_XLEN-32){1'b0}}, i_riscv_csr_inst};
    end
    else if (i_riscv_csr_inst_addr_misaligned)
      o_riscv_csr_trap_cause = CAUSE_INST_MISALIGNED;
    else if (i_riscv_csr_ecall)
      o_riscv_csr_trap_cause = (i_riscv_csr_priv == PRIV_M) ? CAUSE_ECALL_M : CAUSE_ECALL_U;
    else if (i_riscv_csr_load_addr_misaligned)
    begin
      o_riscv_csr_trap_cause = CAUSE_LOAD_MISALIGNED;
      o_riscv_csr_tval_wr    = 1'b1;
    end
    else if (i_riscv_csr_store_addr_misaligned)
    begin
      o_riscv_csr_trap_cause = CAUSE_STORE_MISALIGNED;
      o_riscv_csr_tval_wr    = 1'b1;
    end
  end

  assign trap_base = {i_riscv_csr_mtvec[`RISCV_CSR_XLEN-1:2], 2'b00};

  // Vectored mode offsets interrupts only
  assign o_riscv_csr_trap_address =
    (i_riscv_csr_mtvec[0] && o_riscv_csr_trap_is_int) ?
    trap_base + {{(`RISCV_CSR_XLEN-6){1'b0}}, o_riscv_csr_trap_cause, 2'b00} : trap_base;

endmodule

//--- riscv_csr_top.sv
`include "riscv_csr_macros.svh"

module riscv_csr_top
  import riscv_csr_pkg::*;
(
  input  logic                       i_riscv_csr_clk,
  input  logic                       i_riscv_csr_rst,
  input  logic [11:0]                i_riscv_csr_address,
  input  csr_op_e                    i_riscv_csr_op,
  input  logic [`RISCV_CSR_XLEN-1:0] i_riscv_csr_wdata,
  input  logic [`RISCV_CSR_XLEN-1:0] i_riscv_csr_pc,
  input  logic [`RISCV_CSR_XLEN-1:0] i_riscv_csr_fault_addr,
  input  logic [31:0]                i_riscv_csr_inst,
  input  logic                       i_riscv_csr_illegal_inst,
  input  logic                       i_riscv_csr_ecall,
  input  logic                       i_riscv_csr_inst_addr_misaligned,
  input  logic                       i_riscv_csr_load_addr_misaligned,
  input  logic                       i_riscv_csr_store_addr_misaligned,
  input  logic                       i_riscv_csr_timer_int,
  input  logic                       i_riscv_csr_external_int,
  input  logic                       i_riscv_csr_flush,
  input  logic                       i_riscv_csr_stall,
  output logic [`RISCV_CSR_XLEN-1:0] o_riscv_csr_rdata,
  output logic                       o_riscv_csr_trap_taken,
  output logic [`RISCV_CSR_XLEN-1:0] o_riscv_csr_trap_address,
  output logic [`RISCV_CSR_XLEN-1:0] o_riscv_csr_return_address,
  output logic                       o_riscv_csr_mret,
  output priv_lvl_e                  o_riscv_csr_privlvl
);

  logic                       read_unknown;
  logic                       wr_en;
  logic [`RISCV_CSR_XLEN-1:0] wr_data;
  logic                       mret;
  logic                       illegal_csr;
  logic                       mstatus_mie;
  logic [`RISCV_CSR_XLEN-1:0] mie;
  logic [`RISCV_CSR_XLEN-1:0] mip;
  logic [`RISCV_CSR_XLEN-1:0] mtvec;
  trap_cause_e                trap_cause;
  logic                       trap_is_int;
  logic                       tval_wr;
  logic [`RISCV_CSR_XLEN-1:0] tval;

  riscv_csr_access u_access (
    .i_riscv_csr_op           (i_riscv_csr_op),
    .i_riscv_csr_address      (i_riscv_csr_address),
    .i_riscv_csr_wdata        (i_riscv_csr_wdata),
    .i_riscv_csr_rdata        (o_riscv_csr_rdata),
    .i_riscv_csr_read_unknown (read_unknown),
    .i_riscv_csr_priv         (o_riscv_csr_privlvl),
    .i_riscv_csr_stall        (i_riscv_csr_stall),
    .o_riscv_csr_wr_en        (wr_en),
    .o_riscv_csr_wr_data      (wr_data),
    .o_riscv_csr_mret         (mret),
    .o_riscv_csr_illegal      (illegal_csr)
  );

  riscv_csr_regs u_regs (
    .i_riscv_csr_clk          (i_riscv_csr_clk),
    .i_riscv_csr_rst          (i_riscv_csr_rst),
    .i_riscv_csr_address      (i_riscv_csr_address),
    .i_riscv_csr_wr_en        (wr_en),
    .i_riscv_csr_wr_data      (wr_data),
    .i_riscv_csr_mret         (mret),
    .i_riscv_csr_trap_taken   (o_riscv_csr_trap_taken),
    .i_riscv_csr_trap_cause   (trap_cause),
    .i_riscv_csr_trap_is_int  (trap_is_int),
    .i_riscv_csr_tval_wr      (tval_wr),
    .i_riscv_csr_tval         (tval),
    .i_riscv_csr_pc           (i_riscv_csr_pc),
    .i_riscv_csr_timer_int    (i_riscv_csr_timer_int),
    .i_riscv_csr_external_int (i_riscv_csr_external_int),
    .o_riscv_csr_rdata        (o_riscv_csr_rdata),
    .o_riscv_csr_read_unknown (read_unknown),
    .o_riscv_csr_priv         (o_riscv_csr_privlvl),
    .o_riscv_csr_mstatus_mie  (mstatus_mie),
    .o_riscv_csr_mie          (mie),
    .o_riscv_csr_mip          (mip),
    .o_riscv_csr_mtvec        (mtvec),
    .o_riscv_csr_mepc         (o_riscv_csr_return_address)
  );

  riscv_csr_trap_ctrl u_trap_ctrl (
    .i_riscv_csr_priv                  (o_riscv_csr_privlvl),
    .i_riscv_csr_mstatus_mie           (mstatus_mie),
    .i_riscv_csr_mie                   (mie),
    .i_riscv_csr_mip                   (mip),
    .i_riscv_csr_mtvec                 (mtvec),
    .i_riscv_csr_illegal_csr           (illegal_csr),
    .i_riscv_csr_illegal_inst          (i_riscv_csr_illegal_inst),
    .i_riscv_csr_ecall                 (i_riscv_csr_ecall),
    .i_riscv_csr_inst_addr_misaligned  (i_riscv_csr_inst_addr_misaligned),
    .i_riscv_csr_load_addr_misaligned  (i_riscv_csr_load_addr_misaligned),
    .i_riscv_csr_store_addr_misaligned (i_riscv_csr_store_addr_misaligned),
    .i_riscv_csr_fault_addr            (i_riscv_csr_fault_addr),
    .i_riscv_csr_inst                  (i_riscv_csr_inst),
    .i_riscv_csr_flush                 (i_riscv_csr_flush),
    .i_riscv_csr_stall                 (i_riscv_csr_stall),
    .o_riscv_csr_trap_taken            (o_riscv_csr_trap_taken),
    .o_riscv_csr_trap_cause            (trap_cause),
    .o_riscv_csr_trap_is_int           (trap_is_int),
    .o_riscv_csr_tval_wr               (tval_wr),
    .o_riscv_csr_tval                  (tval),
    .o_riscv_csr_trap_address          (o_riscv_csr_trap_address)
  );

  assign o_riscv_csr_mret = mret && !o_riscv_csr_trap_taken;  // A trap overrides the return

endmodule

//--- riscv_csr_chk.sv
module riscv_csr_chk
  import riscv_csr_pkg::*;
(
  input logic      i_riscv_csr_clk,
  input logic      i_riscv_csr_rst,
  input logic      i_riscv_csr_stall,
  input logic      i_riscv_csr_trap_taken,
  input logic      i_riscv_csr_mret,
  input priv_lvl_e i_riscv_csr_privlvl
);

  no_trap_in_stall : assert property (@(posedge i_riscv_csr_clk) disable iff (i_riscv_csr_rst)
    i_riscv_csr_stall |-> !i_riscv_csr_trap_taken)
  else
    $error("Trap taken while the pipeline is stalled");

  priv_legal : assert property (@(posedge i_riscv_csr_clk) disable iff (i_riscv_csr_rst)
    (i_riscv_csr_privlvl == PRIV_M) || (i_riscv_csr_privlvl == PRIV_U))
  else
    $error("Privilege level is neither M nor U");

  // A trap always overrides MRET
  no_mret_on_trap : assert property (@(posedge i_riscv_csr_clk) disable iff (i_riscv_csr_rst)
    i_riscv_csr_trap_taken |-> !i_riscv_csr_mret)
  else
    $error("MRET strobe high together with a trap");

endmodule

bind riscv_csr_top riscv_csr_chk u_chk (
  .i_riscv_csr_clk        (i_riscv_csr_clk),
  .i_riscv_csr_rst        (i_riscv_csr_rst),
  .i_riscv_csr_stall      (i_riscv_csr_stall),
  .i_riscv_csr_trap_taken (o_riscv_csr_trap_taken),
  .i_riscv_csr_mret       (o_riscv_csr_mret),
  .i_riscv_csr_privlvl    (o_riscv_csr_privlvl)
);

//--- tb_riscv_csr.sv
`include "riscv_csr_macros.svh"

module tb_riscv_csr
  import riscv_csr_pkg::*;
();

  localparam int NUM_CYCLES    = 4000;
  localparam int RESET_TIMEOUT = 20;
  // Weighted address list, last three are not implemented
  localparam logic [11:0] ADDR_LIST [16] = '{
    12'h300, 12'h301, 12'h304, 12'h305, 12'h340, 12'h341, 12'h342, 12'h343,
    12'h344, 12'hF14, 12'h300, 12'h304, 12'h341, 12'h000, 12'h7C0, 12'hC00
  };

  logic                       i_riscv_csr_clk;
  logic                       i_riscv_csr_rst;
  logic [11:0]                i_riscv_csr_address;
  csr_op_e                    i_riscv_csr_op;
  logic [`RISCV_CSR_XLEN-1:0] i_riscv_csr_wdata;
  logic [`RISCV_CSR_XLEN-1:0] i_riscv_csr_pc;
  logic [`RISCV_CSR_XLEN-1:0] i_riscv_csr_fault_addr;
  logic [31:0]                i_riscv_csr_inst;
  logic                       i_riscv_csr_illegal_inst;
  logic                       i_riscv_csr_ecall;
  logic                       i_riscv_csr_inst_addr_misaligned;
  logic                       i_riscv_csr_load_addr_misaligned;
  logic                       i_riscv_csr_store_addr_misaligned;
  logic                       i_riscv_csr_timer_int;
  logic                       i_riscv_csr_external_int;
  logic                       i_riscv_csr_flush;
  logic                       i_riscv_csr_stall;
  logic [`RISCV_CSR_XLEN-1:0] o_riscv_csr_rdata;
  logic                       o_riscv_csr_trap_taken;
  logic [`RISCV_CSR_XLEN-1:0] o_riscv_csr_trap_address;
  logic [`RISCV_CSR_XLEN-1:0] o_riscv_csr_return_address;
  logic                       o_riscv_csr_mret;
  priv_lvl_e                  o_riscv_csr_privlvl;

  // Reference model state, starts at reset values
  logic [63:0] mdl_mstatus  = 64'h0;
  logic [1:0]  mdl_priv     = 2'b11;
  logic [63:0] mdl_mie      = 64'h0;
  logic [63:0] mdl_mip      = 64'h0;
  logic [63:0] mdl_mtvec    = 64'h48;
  logic [63:0] mdl_mscratch = 64'h0;
  logic [63:0] mdl_mepc     = 64'h0;
  logic [63:0] mdl_mcause   = 64'h0;
  logic [63:0] mdl_mtval    = 64'h0;

  logic [31:0] seed;
  int          err_count;
  int          chk_count;

  riscv_csr_top uut (.*);

  initial
  begin
    i_riscv_csr_clk = 1'b0;
    forever #50 i_riscv_csr_clk = ~i_riscv_csr_clk;
  end

  function automatic logic [31:0] next_rand();
    seed = seed ^ (seed << 13);
    seed = seed ^ (seed >> 17);
    seed = seed ^ (seed << 5);
    return seed;
  endfunction

  function automatic logic [63:0] read_model(input logic [11:0] addr, output logic unknown);
    unknown = 1'b0;
    case (addr)
      12'h300 : return mdl_mstatus;
      12'h301 : return 64'h8000_0000_0010_0100;  // MXL=2, I and U
      12'h304 : return mdl_mie;
      12'h305 : return mdl_mtvec;
      12'h340 : return mdl_mscratch;
      12'h341 : return mdl_mepc;
      12'h342 : return mdl_mcause;
      12'h343 : return mdl_mtval;
      12'h344 : return mdl_mip;
      12'hF14 : return 64'h0;
      default :
      begin
        unknown = 1'b1;
        return 64'h0;
      end
    endcase
  endfunction

  task automatic check_value(input string name, input logic [63:0] got, input logic [63:0] exp);
    chk_count++;
    assert (got === exp)
    else
    begin
      err_count++;
      $display("Fail %s at %0t: got %h expected %h", name, $time, got, exp);
    end
  endtask

  task automatic drive_random();
    logic [31:0] r [4];
    for (int k = 0; k < 4; k++)
      r[k] = next_rand();
    i_riscv_csr_op      = csr_op_e'(r[0][2:0]);
    i_riscv_csr_address = ADDR_LIST[r[0][7:4]];
    {i_riscv_csr_illegal_inst, i_riscv_csr_ecall, i_riscv_csr_inst_addr_misaligned,
     i_riscv_csr_load_addr_misaligned, i_riscv_csr_store_addr_misaligned} =
      r[0][20:16] & r[1][20:16] & r[2][20:16] & r[3][20:16];  // One in 16 each
    {i_riscv_csr_stall, i_riscv_csr_flush} = r[1][1:0] & r[2][1:0] & r[3][1:0];
    {i_riscv_csr_timer_int, i_riscv_csr_external_int} = r[1][9:8] & r[2][9:8];
    i_riscv_csr_inst       = r[3];
    i_riscv_csr_wdata      = {next_rand(), next_rand()};
    i_riscv_csr_pc         = {next_rand(), next_rand()};
    i_riscv_csr_fault_addr = {next_rand(), next_rand()};
  endtask

  task automatic check_and_step();
    logic [63:0] rd;
    logic [63:0] wd;
    logic [63:0] tval;
    logic [63:0] target;
    logic [3:0]  cause;
    logic        unknown;
    logic        is_write;
    logic        illegal;
    logic        int_en;
    logic        irq;
    logic        exc;
    logic        trap;
    logic        tval_wr;
    logic        ret;
    rd       = read_model(i_riscv_csr_address, unknown);
    is_write = (i_riscv_csr_op == CSR_WRITE) || (i_riscv_csr_op == CSR_SET) ||
               (i_riscv_csr_op == CSR_CLEAR);
    illegal  = (is_write || (i_riscv_csr_op == CSR_READ)) &&
               (unknown || (is_write && (i_riscv_csr_address[11:10] == 2'b11)) ||
                (i_riscv_csr_address[9:8] > mdl_priv));
    case (i_riscv_csr_op)
      CSR_SET   : wd = rd | i_riscv_csr_wdata;
      CSR_CLEAR : wd = rd & ~i_riscv_csr_wdata;
      default   : wd = i_riscv_csr_wdata;
    endcase
    int_en  = (mdl_priv == 2'b00) || mdl_mstatus[3];
    cause   = 4'd0;
    tval    = i_riscv_csr_fault_addr;
    tval_wr = 1'b0;
    irq     = 1'b1;
    if (int_en && mdl_mie[11] && mdl_mip[11])
      cause = 4'd11;  // MEI first
    else if (int_en && mdl_mie[7] && mdl_mip[7])
      cause = 4'd7;
    else
    begin
      irq = 1'b0;
      if (illegal || i_riscv_csr_illegal_inst)
      begin
        cause   = 4'd2;
        tval    = {32'h0, i_riscv_csr_inst};
        tval_wr = 1'b1;
      end
      else if (i_riscv_csr_inst_addr_misaligned)
        cause = 4'd0;
      else if (i_riscv_csr_ecall)
        cause = (mdl_priv == 2'b11) ? 4'd11 : 4'd8;
      else if (i_riscv_csr_load_addr_misaligned || i_riscv_csr_store_addr_misaligned)
      begin
        cause   = i_riscv_csr_load_addr_misaligned ? 4'd4 : 4'd6;
        tval_wr = 1'b1;
      end
    end
    exc    = illegal || i_riscv_csr_illegal_inst || i_riscv_csr_inst_addr_misaligned ||
             i_riscv_csr_ecall || i_riscv_csr_load_addr_misaligned ||
             i_riscv_csr_store_addr_misaligned;
    trap   = (irq || exc) && !i_riscv_csr_flush && !i_riscv_csr_stall;
    ret    = (i_riscv_csr_op == CSR_MRET) && !i_riscv_csr_stall && !trap;
    target = {mdl_mtvec[63:2], 2'b00} + ((mdl_mtvec[0] && irq) ? {58'h0, cause, 2'b00} : 64'h0);

    check_value("o_riscv_csr_rdata", o_riscv_csr_rdata, rd);
    check_value("o_riscv_csr_trap_taken", o_riscv_csr_trap_taken, trap);
    if (trap)
      check_value("o_riscv_csr_trap_address", o_riscv_csr_trap_address, target);
    check_value("o_riscv_csr_return_address", o_riscv_csr_return_address, mdl_mepc);
    check_value("o_riscv_csr_mret", o_riscv_csr_mret, ret);
    check_value("o_riscv_csr_privlvl", o_riscv_csr_privlvl, mdl_priv);

    // State after the coming edge
    if (trap)
    begin
      mdl_mepc    = i_riscv_csr_pc;
      mdl_mcause  = {irq, 59'h0, cause};
      if (tval_wr)
        mdl_mtval = tval;
      mdl_mstatus = {51'h0, mdl_priv, 3'b000, mdl_mstatus[3], 7'h0};
      mdl_priv    = 2'b11;
    end
    else if (ret)
    begin
      mdl_priv    = mdl_mstatus[12:11];
      mdl_mstatus = {56'h0, 1'b1, 3'b000, mdl_mstatus[7], 3'b000};  // MPP back to U
    end
    else if (is_write && !illegal && !i_riscv_csr_stall)
    begin
      case (i_riscv_csr_address)
        12'h300 : mdl_mstatus = {51'h0, {2{wd[12] & wd[11]}}, 3'b000, wd[7], 3'b000, wd[3],
                                 3'b000};
        12'h304 : mdl_mie      = wd & 64'h880;
        12'h305 : mdl_mtvec    = {wd[63:2], 1'b0, wd[0]};
        12'h340 : mdl_mscratch = wd;
        12'h341 : mdl_mepc     = {wd[63:1], 1'b0};
        12'h342 : mdl_mcause   = {wd[63], 59'h0, wd[3:0]};
        12'h343 : mdl_mtval    = wd;
        default : mdl_mtval    = mdl_mtval;  // MIP and constants ignore writes
      endcase
    end
    mdl_mip = {52'h0, i_riscv_csr_external_int, 3'b000, i_riscv_csr_timer_int, 7'h0};
  endtask

  initial
  begin
    logic ready;
    seed      = 32'hbf69_1206;
    err_count = 0;
    chk_count = 0;
    ready     = 1'b0;
    i_riscv_csr_rst        = 1'b1;
    i_riscv_csr_op         = CSR_NONE;
    i_riscv_csr_address    = 12'h0;
    i_riscv_csr_wdata      = 64'h0;
    i_riscv_csr_pc         = 64'h0;
    i_riscv_csr_fault_addr = 64'h0;
    i_riscv_csr_inst       = 32'h0;
    {i_riscv_csr_illegal_inst, i_riscv_csr_ecall, i_riscv_csr_inst_addr_misaligned,
     i_riscv_csr_load_addr_misaligned, i_riscv_csr_store_addr_misaligned,
     i_riscv_csr_timer_int, i_riscv_csr_external_int, i_riscv_csr_flush,
     i_riscv_csr_stall} = '0;
    repeat (2) @(posedge i_riscv_csr_clk);
    #10 i_riscv_csr_rst = 1'b0;
    for (int i = 0; (i < RESET_TIMEOUT) && !ready; i++)
    begin
      @(posedge i_riscv_csr_clk);
      #10 ready = (o_riscv_csr_privlvl == PRIV_M) && !o_riscv_csr_trap_taken;
    end
    if (!ready)
    begin
      err_count++;
      $display("Timeout waiting for the DUT to leave reset in M mode");
    end
    else
    begin
      for (int i = 0; i < NUM_CYCLES; i++)
      begin
        @(posedge i_riscv_csr_clk);
        #10 drive_random();
        #40 check_and_step();  // Mid cycle, outputs settled
      end
    end
    $display("Checks: %0d, errors: %0d", chk_count, err_count);
    if (err_count == 0)
      $display("RESULT: PASS");
    else
      $display("RESULT: FAIL");
    $finish;
  end

endmodule

//--- flist.f
+incdir+.
riscv_csr_pkg.sv
riscv_csr_access.sv
riscv_csr_regs.sv
riscv_csr_trap_ctrl.sv
riscv_csr_top.sv
riscv_csr_chk.sv
tb_riscv_csr.sv
